// File: hw/lcd_clock_pkg.sv
// Shared types and LCD command and glyph codes for the clock display controller
`default_nettype none

package lcd_clock_pkg;

    // Controller states, in the order they are visited
    typedef enum logic [2:0]
    {
        power_up,
        function_set,
        display_on,
        entry_mode,
        line1,
        line2,
        home
    } lcd_state_e;

    // Upper bit selects alarm view, lower bit marks setting
    typedef enum logic [1:0]
    {
        current_time,
        current_set,
        alarm_time,
        alarm_set
    } clock_mode_e;

    typedef enum logic [2:0]
    {
        blink_none,
        blink_hour,
        blink_min,
        blink_sec,
        blink_meridian,
        blink_year,
        blink_month,
        blink_day
    } blink_field_e;

    typedef logic [7:0] char_t;
    typedef logic [7:0] slot_t;

    localparam char_t cmd_function_set = 8'h3C; // 8-bit bus, two lines, 5x10 font
    localparam char_t cmd_display_on   = 8'h0C; // Display on, no cursor
    localparam char_t cmd_entry_mode   = 8'h06; // Increment, no shift
    localparam char_t cmd_line1_addr   = 8'h80;
    localparam char_t cmd_line2_addr   = 8'hC0;
    localparam char_t cmd_return_home  = 8'h02;

    localparam char_t ch_space   = 8'h20;
    localparam char_t ch_colon   = 8'h3A;
    localparam char_t ch_two     = 8'h32;
    localparam char_t ch_zero    = 8'h30;
    localparam char_t ch_y       = 8'h59;
    localparam char_t ch_m       = 8'h4D;
    localparam char_t ch_d       = 8'h44;
    localparam char_t ch_alarm   = 8'h98; // Bell glyph in the module's ROM
    localparam char_t ch_setting = 8'hA9;
    localparam char_t ch_note    = 8'h91;

    // Address slot plus sixteen characters
    localparam slot_t line_slots = 8'd17;

endpackage

`default_nettype wire

// File: hw/lcd_sequencer.sv
// Steps the LCD through power-up, init commands and the endless refresh frame
`default_nettype none

module lcd_sequencer
#(
    parameter int power_up_cycles = 71,
    parameter int command_cycles  = 31,
    parameter int line_cycles     = 21,
    parameter int home_cycles     = 57
)
(
    input  logic                      CLK,
    input  logic                      RESETN,
    output lcd_clock_pkg::lcd_state_e state,
    output lcd_clock_pkg::slot_t      slot,
    output logic                      blink_phase
);

    import lcd_clock_pkg::*;

    slot_t      last_slot;
    lcd_state_e next_state;

    // Length of the current state, minus one
    always_comb
    begin
        case (state)
            power_up:
                last_slot = slot_t'(power_up_cycles - 1);
            function_set, display_on, entry_mode:
                last_slot = slot_t'(command_cycles - 1);
            line1, line2:
                last_slot = slot_t'(line_cycles - 1);
            default:
                last_slot = slot_t'(home_cycles - 1);
        endcase
    end

    always_comb
    begin
        case (state)
            power_up:     next_state = function_set;
            function_set: next_state = display_on;
            display_on:   next_state = entry_mode;
            entry_mode:   next_state = line1;
            line1:        next_state = line2;
            line2:        next_state = home;
            home:         next_state = line1; // Frame loops forever
            default:      next_state = power_up;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            state       <= power_up;
            slot        <= '0;
            blink_phase <= 1'b0;
        end
        else if (slot == last_slot)
        begin
            state <= next_state;
            slot  <= '0;
            if (state == home)
            begin
                blink_phase <= ~blink_phase; // Once per frame
            end
        end
        else
        begin
            slot <= slot + 8'd1;
        end
    end

endmodule

`default_nettype wire

// File: hw/lcd_char_select.sv
// Chooses the character shown at each slot of both display lines
`default_nettype none

module lcd_char_select
(
    input  lcd_clock_pkg::lcd_state_e   state,
    input  lcd_clock_pkg::slot_t        slot,
    input  logic                        blink_phase,
    input  lcd_clock_pkg::char_t        h10,
    input  lcd_clock_pkg::char_t        h1,
    input  lcd_clock_pkg::char_t        m10,
    input  lcd_clock_pkg::char_t        m1,
    input  lcd_clock_pkg::char_t        s10,
    input  lcd_clock_pkg::char_t        s1,
    input  lcd_clock_pkg::char_t        y10,
    input  lcd_clock_pkg::char_t        y1,
    input  lcd_clock_pkg::char_t        mt10,
    input  lcd_clock_pkg::char_t        mt1,
    input  lcd_clock_pkg::char_t        d10,
    input  lcd_clock_pkg::char_t        d1,
    input  lcd_clock_pkg::char_t        meridian,
    input  logic                        time_format,
    input  lcd_clock_pkg::clock_mode_e  mode,
    input  lcd_clock_pkg::blink_field_e blink,
    input  logic                        ring_alarm,
    input  logic                        set_alarm,
    output lcd_clock_pkg::char_t        char_code
);

    import lcd_clock_pkg::*;

    char_t line1_char;
    char_t line2_char;
    char_t colon_char;
    logic  alarm_view;
    logic  setting;

    // Blank a field on the off phase when the selector points at it
    function automatic char_t field_char(input blink_field_e sel, input blink_field_e field,
                                         input logic phase, input char_t ch);
        field_char = (sel == field && phase) ? ch_space : ch;
    endfunction

    assign colon_char = blink_phase ? ch_space : ch_colon;
    assign alarm_view = (mode == alarm_time) || (mode == alarm_set);
    assign setting    = (mode == current_set) || (mode == alarm_set);

    always_comb
    begin
        case (slot)
            8'd2:  line1_char = field_char(blink, blink_hour, blink_phase, h10);
            8'd3:  line1_char = field_char(blink, blink_hour, blink_phase, h1);
            8'd4:  line1_char = colon_char;
            8'd5:  line1_char = field_char(blink, blink_min, blink_phase, m10);
            8'd6:  line1_char = field_char(blink, blink_min, blink_phase, m1);
            8'd7:  line1_char = colon_char;
            8'd8:  line1_char = field_char(blink, blink_sec, blink_phase, s10);
            8'd9:  line1_char = field_char(blink, blink_sec, blink_phase, s1);
            8'd11: line1_char = time_format ?
                                field_char(blink, blink_meridian, blink_phase, meridian) :
                                ch_space;
            8'd12: line1_char = time_format ?
                                field_char(blink, blink_meridian, blink_phase, ch_m) :
                                ch_space;
            8'd14: line1_char = alarm_view ? ch_alarm : ch_space;
            8'd15: line1_char = setting ? ch_setting : ch_space;
            default: line1_char = ch_space; // Padding slots 1, 10, 13, 16
        endcase
    end

    always_comb
    begin
        case (slot)
            8'd2:  line2_char = field_char(blink, blink_year, blink_phase, ch_two);
            8'd3:  line2_char = field_char(blink, blink_year, blink_phase, ch_zero);
            8'd4:  line2_char = field_char(blink, blink_year, blink_phase, y10);
            8'd5:  line2_char = field_char(blink, blink_year, blink_phase, y1);
            8'd6:  line2_char = ch_y;
            8'd7:  line2_char = field_char(blink, blink_month, blink_phase, mt10);
            8'd8:  line2_char = field_char(blink, blink_month, blink_phase, mt1);
            8'd9:  line2_char = ch_m;
            8'd10: line2_char = field_char(blink, blink_day, blink_phase, d10);
            8'd11: line2_char = field_char(blink, blink_day, blink_phase, d1);
            8'd12: line2_char = ch_d;
            8'd14: line2_char = ring_alarm ? ch_note : ch_space;
            8'd15: line2_char = set_alarm ? ch_alarm : ch_space;
            default: line2_char = ch_space;
        endcase
    end

    always_comb
    begin
        if (slot >= line_slots)
        begin
            char_code = ch_space; // Tail of a long line state
        end
        else if (state == line1)
        begin
            char_code = line1_char;
        end
        else if (state == line2)
        begin
            char_code = line2_char;
        end
        else
        begin
            char_code = ch_space;
        end
    end

endmodule

`default_nettype wire

// File: hw/lcd_bus_driver.sv
// Registers the LCD bus with command bytes or display characters per state
`default_nettype none

module lcd_bus_driver
(
    input  logic                      CLK,
    input  logic                      RESETN,
    input  lcd_clock_pkg::lcd_state_e state,
    input  lcd_clock_pkg::slot_t      slot,
    input  lcd_clock_pkg::char_t      char_code,
    output logic                      lcd_rs,
    output logic                      lcd_rw,
    output lcd_clock_pkg::char_t      lcd_data
);

    import lcd_clock_pkg::*;

    char_t      line_addr;

    assign line_addr = (state == line1) ? cmd_line1_addr : cmd_line2_addr;

    always_ff @(posedge CLK)
    begin
        if (!RESETN)
        begin
            lcd_rs   <= 1'b1;
            lcd_rw   <= 1'b1;
            lcd_data <= '0;
        end
        else
        begin
            lcd_rw <= 1'b0;
            lcd_rs <= 1'b0;
            case (state)
                function_set: lcd_data <= cmd_function_set;
                display_on:   lcd_data <= cmd_display_on;
                entry_mode:   lcd_data <= cmd_entry_mode;
                home:         lcd_data <= cmd_return_home;
                line1, line2:
                begin
                    if (slot == '0)
                    begin
                        lcd_data <= line_addr; // DDRAM address first
                    end
                    else
                    begin
                        lcd_rs   <= 1'b1;
                        lcd_data <= char_code;
                    end
                end
                default:
                begin
                    lcd_rs   <= 1'b1; // Bus idles during power-up wait
                    lcd_rw   <= 1'b1;
                    lcd_data <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/lcd_clock_top.sv
// Character-LCD controller for a digital clock, sequencer plus bus datapath
`default_nettype none

module lcd_clock_top
#(
    parameter int power_up_cycles = 71,
    parameter int command_cycles  = 31,
    parameter int line_cycles     = 21, // At least line_slots
    parameter int home_cycles     = 57
)
(
    input  logic                        CLK,
    input  logic                        RESETN,
    input  lcd_clock_pkg::char_t        h10,
    input  lcd_clock_pkg::char_t        h1,
    input  lcd_clock_pkg::char_t        m10,
    input  lcd_clock_pkg::char_t        m1,
    input  lcd_clock_pkg::char_t        s10,
    input  lcd_clock_pkg::char_t        s1,
    input  lcd_clock_pkg::char_t        y10,
    input  lcd_clock_pkg::char_t        y1,
    input  lcd_clock_pkg::char_t        mt10,
    input  lcd_clock_pkg::char_t        mt1,
    input  lcd_clock_pkg::char_t        d10,
    input  lcd_clock_pkg::char_t        d1,
    input  lcd_clock_pkg::char_t        meridian,
    input  logic                        time_format,
    input  lcd_clock_pkg::clock_mode_e  mode,
    input  lcd_clock_pkg::blink_field_e blink,
    input  logic                        ring_alarm,
    input  logic                        set_alarm,
    output logic                        lcd_rs,
    output logic                        lcd_rw,
    output lcd_clock_pkg::char_t        lcd_data
);

    import lcd_clock_pkg::*;

    lcd_state_e state;
    slot_t      slot;
    logic       blink_phase;
    char_t      char_code;

    lcd_sequencer
    #(
        .power_up_cycles (power_up_cycles),
        .command_cycles  (command_cycles),
        .line_cycles     (line_cycles),
        .home_cycles     (home_cycles)
    )
    i_lcd_sequencer
    (
        .CLK         (CLK),
        .RESETN      (RESETN),
        .state       (state),
        .slot        (slot),
        .blink_phase (blink_phase)
    );

    lcd_char_select i_lcd_char_select
    (
        .state       (state),
        .slot        (slot),
        .blink_phase (blink_phase),
        .h10         (h10),
        .h1          (h1),
        .m10         (m10),
        .m1          (m1),
        .s10         (s10),
        .s1          (s1),
        .y10         (y10),
        .y1          (y1),
        .mt10        (mt10),
        .mt1         (mt1),
        .d10         (d10),
        .d1          (d1),
        .meridian    (meridian),
        .time_format (time_format),
        .mode        (mode),
        .blink       (blink),
        .ring_alarm  (ring_alarm),
        .set_alarm   (set_alarm),
        .char_code   (char_code)
    );

    lcd_bus_driver i_lcd_bus_driver
    (
        .CLK       (CLK),
        .RESETN    (RESETN),
        .state     (state),
        .slot      (slot),
        .char_code (char_code),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data)
    );

endmodule

`default_nettype wire

// File: sim/lcd_ref_model.svh
// Reference model of the LCD bus for the clock display, with LCG and compare tasks
`ifndef lcd_ref_model_svh
`define lcd_ref_model_svh

localparam int ref_power_up = 71;
localparam int ref_command  = 31;
localparam int ref_line     = 21;
localparam int ref_home     = 57;
localparam int init_cycles  = ref_power_up + 3 * ref_command;
localparam int frame_cycles = 2 * ref_line + ref_home;

typedef struct packed
{
    logic  rs;
    logic  rw;
    char_t data;
} bus_word_t;

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    lcg_next = s * 32'd1664525 + 32'd1013904223;
endfunction

// Sequencer time of the last home cycle of frame n
function automatic int frame_last_cycle(input int n);
    frame_last_cycle = init_cycles + n * frame_cycles + frame_cycles - 1;
endfunction

function automatic char_t line1_ref(input int pos, input logic phase);
    logic  hour_off;
    logic  min_off;
    logic  sec_off;
    logic  mer_off;
    char_t c;
    hour_off = phase && (blink == blink_hour);
    min_off  = phase && (blink == blink_min);
    sec_off  = phase && (blink == blink_sec);
    mer_off  = phase && (blink == blink_meridian);
    c = " ";
    case (pos)
        2:       if (!hour_off) c = h10;
        3:       if (!hour_off) c = h1;
        4, 7:    if (!phase) c = ":";
        5:       if (!min_off) c = m10;
        6:       if (!min_off) c = m1;
        8:       if (!sec_off) c = s10;
        9:       if (!sec_off) c = s1;
        11:      if (time_format && !mer_off) c = meridian;
        12:      if (time_format && !mer_off) c = "M";
        14:      if (mode[1]) c = ch_alarm; // Alarm view
        15:      if (mode[0]) c = ch_setting;
        default: c = " ";
    endcase
    line1_ref = c;
endfunction

function automatic char_t line2_ref(input int pos, input logic phase);
    logic  year_off;
    logic  month_off;
    logic  day_off;
    char_t c;
    year_off  = phase && (blink == blink_year);
    month_off = phase && (blink == blink_month);
    day_off   = phase && (blink == blink_day);
    c = " ";
    case (pos)
        2:       if (!year_off) c = "2";
        3:       if (!year_off) c = "0";
        4:       if (!year_off) c = y10;
        5:       if (!year_off) c = y1;
        6:       c = "Y";
        7:       if (!month_off) c = mt10;
        8:       if (!month_off) c = mt1;
        9:       c = "M";
        10:      if (!day_off) c = d10;
        11:      if (!day_off) c = d1;
        12:      c = "D";
        14:      if (ring_alarm) c = ch_note;
        15:      if (set_alarm) c = ch_alarm;
        default: c = " ";
    endcase
    line2_ref = c;
endfunction

// Expected bus after the edge at sequencer time t
function automatic bus_word_t expected_bus(input int t);
    bus_word_t w;
    int        off;
    logic      phase;
    w.rs   = 1'b0;
    w.rw   = 1'b0;
    w.data = 8'h00;
    off    = (t - init_cycles) % frame_cycles;
    phase  = ((t - init_cycles) / frame_cycles) % 2 == 1; // Odd frames blank
    if (t < ref_power_up)
    begin
        w.rs = 1'b1;
        w.rw = 1'b1;
    end
    else if (t < ref_power_up + ref_command)
        w.data = cmd_function_set;
    else if (t < ref_power_up + 2 * ref_command)
        w.data = cmd_display_on;
    else if (t < init_cycles)
        w.data = cmd_entry_mode;
    else if (off == 0)
        w.data = cmd_line1_addr;
    else if (off < ref_line)
    begin
        w.rs   = 1'b1;
        w.data = line1_ref(off, phase);
    end
    else if (off == ref_line)
        w.data = cmd_line2_addr;
    else if (off < 2 * ref_line)
    begin
        w.rs   = 1'b1;
        w.data = line2_ref(off - ref_line, phase);
    end
    else
        w.data = cmd_return_home;
    expected_bus = w;
endfunction

task automatic check_bit(input string name, input logic actual, input logic expected,
                         input int t);
    check_count = check_count + 1;
    if (actual !== expected)
    begin
        error_count = error_count + 1;
        test_errors = test_errors + 1;
        $display("error %s: got 0x%h, expected 0x%h at cycle %0d", name, actual, expected, t);
    end
endtask

task automatic check_char(input string name, input char_t actual, input char_t expected,
                          input int t);
    check_count = check_count + 1;
    if (actual !== expected)
    begin
        error_count = error_count + 1;
        test_errors = test_errors + 1;
        $display("error %s: got 0x%h, expected 0x%h at cycle %0d", name, actual, expected, t);
    end
endtask

`endif

// File: sim/tb_lcd_clock.sv
// Testbench for the clock LCD controller, checks every bus cycle against a model
`default_nettype none

module tb_lcd_clock;

    import lcd_clock_pkg::*;

    localparam int num_tests    = 5;
    localparam int total_frames = 24;

    logic         CLK = 1'b0;
    logic         RESETN;
    char_t        h10;
    char_t        h1;
    char_t        m10;
    char_t        m1;
    char_t        s10;
    char_t        s1;
    char_t        y10;
    char_t        y1;
    char_t        mt10;
    char_t        mt1;
    char_t        d10;
    char_t        d1;
    char_t        meridian;
    logic         time_format;
    clock_mode_e  mode;
    blink_field_e blink;
    logic         ring_alarm;
    logic         set_alarm;
    logic         lcd_rs;
    logic         lcd_rw;
    char_t        lcd_data;

    logic [31:0]  rng_state   = 32'hdb8a;
    int           cycle_count = 0; // Edges since reset release
    int           run_cycles  = 0;
    int           check_count = 0;
    int           error_count = 0;
    int           test_errors = 0;
    int           test_idx    = 0;
    logic         all_done    = 1'b0;
    string        test_name [num_tests];
    int           test_last [num_tests];

    `include "lcd_ref_model.svh"

    localparam int cycle_limit = 16 + init_cycles + total_frames * frame_cycles + 64;

    lcd_clock_top i_lcd_clock_top
    (
        .CLK         (CLK),
        .RESETN      (RESETN),
        .h10         (h10),
        .h1          (h1),
        .m10         (m10),
        .m1          (m1),
        .s10         (s10),
        .s1          (s1),
        .y10         (y10),
        .y1          (y1),
        .mt10        (mt10),
        .mt1         (mt1),
        .d10         (d10),
        .d1          (d1),
        .meridian    (meridian),
        .time_format (time_format),
        .mode        (mode),
        .blink       (blink),
        .ring_alarm  (ring_alarm),
        .set_alarm   (set_alarm),
        .lcd_rs      (lcd_rs),
        .lcd_rw      (lcd_rw),
        .lcd_data    (lcd_data)
    );

    always #2 CLK = ~CLK;

    function automatic int rand_below(input int n);
        rng_state  = lcg_next(rng_state);
        rand_below = int'(rng_state[30:16]) % n;
    endfunction

    function automatic char_t digit(input int n);
        digit = char_t'(8'h30 + 8'(rand_below(n)));
    endfunction

    // New values for frame fr, applied during the last home cycle before it
    task automatic apply_frame_inputs(input int fr);
        h10      = digit(3);
        h1       = digit(10);
        m10      = digit(6);
        m1       = digit(10);
        s10      = digit(6);
        s1       = digit(10);
        y10      = digit(10);
        y1       = digit(10);
        mt10     = digit(2);
        mt1      = digit(10);
        d10      = digit(4);
        d1       = digit(10);
        meridian = (rand_below(2) == 0) ? "A" : "P";
        mode     = clock_mode_e'(2'(rand_below(4)));
        if (fr < 4)
        begin
            time_format = 1'b0;
            blink       = blink_none;
            mode        = clock_mode_e'(fr[1:0]); // One frame per mode
            ring_alarm  = 1'b0;
            set_alarm   = 1'b0;
        end
        else if (fr < 8)
        begin
            time_format = 1'b1;
            blink       = blink_none;
            ring_alarm  = fr[0];
            set_alarm   = fr[1];
        end
        else if (fr < 22)
        begin
            time_format = 1'b1;
            blink       = blink_field_e'(3'((fr - 8) / 2 + 1)); // Even then odd frame
            ring_alarm  = rand_below(2) == 1;
            set_alarm   = rand_below(2) == 1;
        end
        else
        begin
            time_format = rand_below(2) == 1;
            blink       = blink_field_e'(3'(rand_below(8)));
            ring_alarm  = rand_below(2) == 1;
            set_alarm   = rand_below(2) == 1;
        end
    endtask

    task automatic wait_for_cycle(input int target);
        while (cycle_count != target)
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    initial
    begin
        test_name[0] = "init_sequence";
        test_last[0] = init_cycles - 1;
        test_name[1] = "mode_marks_24h";
        test_last[1] = frame_last_cycle(3);
        test_name[2] = "meridian_colon_date";
        test_last[2] = frame_last_cycle(7);
        test_name[3] = "field_blink";
        test_last[3] = frame_last_cycle(21);
        test_name[4] = "random_frames";
        test_last[4] = frame_last_cycle(23);
        RESETN = 1'b0;
        apply_frame_inputs(0);
        repeat (16) @(posedge CLK);
        #1;
        RESETN = 1'b1;
        for (int fr = 1; fr < total_frames; fr++)
        begin
            wait_for_cycle(frame_last_cycle(fr - 1));
            apply_frame_inputs(fr);
        end
    end

    always @(posedge CLK)
    begin
        if (!RESETN)
            cycle_count <= 0;
        else
            cycle_count <= cycle_count + 1;
    end

    always @(posedge CLK)
    begin : compare_bus
        bus_word_t want;
        int        t;
        logic      active;
        active = RESETN;
        t      = active ? cycle_count : 0; // Reset looks like power-up
        want   = expected_bus(t);
        #2;
        check_bit("lcd_rs", lcd_rs, want.rs, t);
        check_bit("lcd_rw", lcd_rw, want.rw, t);
        check_char("lcd_data", lcd_data, want.data, t);
        if (active && test_idx < num_tests && t == test_last[test_idx])
        begin
            $display("test %s: %0d errors", test_name[test_idx], test_errors);
            test_errors = 0;
            test_idx    = test_idx + 1;
            all_done    = test_idx == num_tests;
        end
    end

    always @(posedge CLK)
    begin
        run_cycles = run_cycles + 1;
        if (run_cycles >= cycle_limit)
        begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial
    begin
        wait (all_done);
        #1;
        $display("tests %0d, checks %0d, errors %0d", num_tests, check_count, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+sim
hw/lcd_clock_pkg.sv
hw/lcd_sequencer.sv
hw/lcd_char_select.sv
hw/lcd_bus_driver.sv
hw/lcd_clock_top.sv
sim/tb_lcd_clock.sv

// File: run_sim.sh
#!/bin/sh
# Build the clock LCD testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_lcd_clock \
    -Mdir obj_dir -o sim_lcd_clock
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_lcd_clock > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
exit 0
